// File: Bender.yml
package:
  name: router_tile

sources:
  - verilog/router_cfg_pkg.sv
  - verilog/router_pkg.sv
  - verilog/fifo.sv
  - verilog/rr_arbiter.sv
  - verilog/route_decoder.sv
  - verilog/fifo_arb.sv
  - verilog/router_tile.sv
  - target: test
    files:
      - dv/tb_router_tile.sv

// File: dv/router_testdata.txt
# S src_port dest_x dest_y payload_hex | M output ready_mask_bin | D fairness_output
# Ports 0 N 1 E 2 S 3 W 4 L, payload top nibble is the source, fairness output 7 is none
S 4 3 1 4001
S 4 0 1 4002
S 2 1 3 2003
S 0 1 0 0004
S 3 1 1 3005
S 1 0 2 1006
S 3 2 0 3007
D 7
M 1 11110
S 4 2 2 4010
S 0 2 0 0011
S 2 3 3 2012
M 1 11111
D 7
M 3 00000
S 4 0 1 4020
S 4 0 1 4021
S 4 0 1 4022
S 4 0 1 4023
M 3 11111
D 7
M 1 00000
S 0 3 1 0030
S 0 3 1 0031
S 2 3 1 2032
S 2 3 1 2033
S 3 3 1 3034
S 3 3 1 3035
S 4 3 1 4036
S 4 3 1 4037
M 1 11111
D 1

// File: dv/tb_router_tile.sv
// Router tile testbench
// Replays send, ready-mask and drain records on tile (1,1) against a payload scoreboard

module tb_router_tile;

    import router_cfg_pkg::*;
    import router_pkg::*;

    localparam int MY_X          = 1;
    localparam int MY_Y          = 1;
    localparam int READY_TIMEOUT = 200;   // Cycles a sender may wait for out_ready
    localparam int DRAIN_TIMEOUT = 1000;
    localparam int NO_FAIR       = 7;     // Drain output id meaning no fairness check

    logic                        clk;
    logic                        rst_n;
    logic [NUM_PORTS-1:0]        in_valid;
    t_tile_trans [NUM_PORTS-1:0] in_req;
    t_port_ready [NUM_PORTS-1:0] out_ready;
    t_tile_trans [NUM_PORTS-1:0] winner_req;
    logic [NUM_PORTS-1:0]        winner_req_valid;
    t_port_ready [NUM_PORTS-1:0] in_ready;

    t_tile_trans exp_q    [NUM_PORTS][$];                     // Expected, per output
    int          exp_src  [NUM_PORTS][$];                     // Source port of each entry
    logic [3:0]  tag_hist [NUM_PORTS][$];                     // Payload tags since last drain
    int          occ      [NUM_PORTS][NUM_PORTS] = '{default: 0};  // [output][source] fill
    integer      seed;

    router_tile #(.TILE_X(MY_X), .TILE_Y(MY_Y)) dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_req           (in_req),
        .out_ready        (out_ready),
        .winner_req       (winner_req),
        .winner_req_valid (winner_req_valid),
        .in_ready         (in_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)",
                     $time, msg, actual, expected);
            stop_on_failure();
        end
    endtask

    // Dimension order, X resolved before Y
    function automatic int xy_dir(int cx, int cy, int dx, int dy);
        if (dx != cx) return (dx > cx) ? EAST : WEST;
        if (dy != cy) return (dy > cy) ? NORTH : SOUTH;
        return LOCAL;
    endfunction

    // Decision the neighbor across output out will make
    function automatic int next_stamp(int out, int dx, int dy);
        int nx;
        int ny;
        if (out == LOCAL) return LOCAL;
        nx = MY_X + (out == EAST) - (out == WEST);
        ny = MY_Y + (out == NORTH) - (out == SOUTH);
        return xy_dir(nx, ny, dx, dy);
    endfunction

    function automatic int pending();
        int n = 0;
        for (int d = 0; d < NUM_PORTS; d++) n += exp_q[d].size();
        return n;
    endfunction

    // Expected entries on an output whose target arbiter is ready right now
    function automatic int ready_backlog(int out);
        int n = 0;
        for (int i = 0; i < exp_q[out].size(); i++) begin
            if (in_ready[out][exp_q[out][i].next_tile_fifo_arb_id])
                n++;
        end
        return n;
    endfunction

    // ========================================================================
    // Monitor, samples on the falling edge while everything is settled
    // ========================================================================
    always @(negedge clk) begin : monitor
        int idx;
        int dir;
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++)     // Ready must track modeled FIFO fill
                for (int d = 0; d < NUM_PORTS; d++)
                    check_eq(out_ready[p][d], occ[d][p] < ARB_FIFO_DEPTH,
                             $sformatf("out_ready[%0d] bit %0d", p, d));
            for (int d = 0; d < NUM_PORTS; d++) begin
                if (winner_req_valid[d]) begin
                    check_eq(in_ready[d][winner_req[d].next_tile_fifo_arb_id], 1'b1,
                             $sformatf("output %0d sent toward a blocked arbiter", d));
                    idx = -1;
                    for (int i = 0; i < exp_q[d].size(); i++)
                        if (exp_q[d][i].payload == winner_req[d].payload) idx = i;
                    check_eq(idx >= 0, 1'b1, $sformatf("output %0d payload %h not expected",
                                                       d, winner_req[d].payload));
                    check_eq(winner_req[d], exp_q[d][idx], $sformatf("output %0d fields", d));
                    occ[d][exp_src[d][idx]]--;       // Popped at the coming edge
                    tag_hist[d].push_back(winner_req[d].payload[15:12]);
                    exp_q[d].delete(idx);
                    exp_src[d].delete(idx);
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (in_valid[p]) begin               // Pushed at the coming edge
                    dir = xy_dir(MY_X, MY_Y, in_req[p].dest.x, in_req[p].dest.y);
                    occ[dir][p]++;
                end
            end
        end
    end

    task automatic send_trans(input int port, input int dx, input int dy,
                              input logic [15:0] payload);
        t_tile_trans tr;
        t_tile_trans exp_tr;
        int          out;
        int          cnt;
        out                      = xy_dir(MY_X, MY_Y, dx, dy);
        tr                       = '0;
        tr.src.x                 = payload[1:0];   // Arbitrary origin, must pass unchanged
        tr.src.y                 = payload[3:2];
        tr.dest.x                = dx;
        tr.dest.y                = dy;
        tr.next_tile_fifo_arb_id = t_cardinal'(out);
        tr.payload               = payload;
        exp_tr                   = tr;
        exp_tr.next_tile_fifo_arb_id = t_cardinal'(next_stamp(out, dx, dy));
        cnt = 0;
        @(negedge clk);
        while (!out_ready[port][out]) begin
            @(negedge clk);
            cnt++;
            if (cnt > READY_TIMEOUT) begin
                $display("Port %0d never saw out_ready for output %0d", port, out);
                stop_on_failure();
            end
        end
        exp_q[out].push_back(exp_tr);
        exp_src[out].push_back(port);
        @(posedge clk);
        in_valid[port] <= 1'b1;
        in_req[port]   <= tr;
        @(posedge clk);
        in_valid[port] <= 1'b0;
        repeat ({$random(seed)} % 4) @(posedge clk);  // Idle gap
    endtask

    // Heads with a ready target keep flowing before the mask moves on
    task automatic set_mask(input int out, input logic [4:0] mask);
        int cnt;
        cnt = 0;
        @(posedge clk);
        while (ready_backlog(out) != 0) begin
            @(posedge clk);
            cnt++;
            if (cnt > DRAIN_TIMEOUT) begin
                $display("Output %0d held back %0d transactions whose target was ready",
                         out, ready_backlog(out));
                stop_on_failure();
            end
        end
        in_ready[out] <= mask;
    endtask

    task automatic drain(input int fair_out);
        int cnt;
        cnt = 0;
        while (pending() != 0) begin
            @(posedge clk);
            cnt++;
            if (cnt > DRAIN_TIMEOUT) begin
                $display("Drain timed out with %0d transactions still expected", pending());
                stop_on_failure();
            end
        end
        if (fair_out != NO_FAIR) begin
            check_eq(tag_hist[fair_out].size() >= 4, 1'b1, "fewer than four fairness strobes");
            for (int i = 0; i + 3 < tag_hist[fair_out].size(); i++)
                for (int a = i; a < i + 4; a++)
                    for (int b = a + 1; b < i + 4; b++)
                        check_eq(tag_hist[fair_out][a] != tag_hist[fair_out][b], 1'b1,
                                 $sformatf("round-robin window at strobe %0d", i));
        end
        for (int d = 0; d < NUM_PORTS; d++) tag_hist[d].delete();
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin : stimulus
        int           fd;
        int           code;
        int           port;
        int           dx;
        int           dy;
        logic [15:0]  payload;
        logic [4:0]   mask;
        logic [63:0]  word;
        logic [1279:0] line;
        logic         done;
        seed     = 32'h8b5c2ad3;
        rst_n    = 1'b0;
        in_valid = '0;
        in_req   = '0;
        in_ready = '1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_eq(winner_req_valid, '0, "winner_req_valid after reset");
        for (int p = 0; p < NUM_PORTS; p++)
            check_eq(out_ready[p], 5'h1f, $sformatf("out_ready[%0d] after reset", p));
        fd = $fopen("dv/router_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/router_testdata.txt");
            stop_on_failure();
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", word);
            if (code != 1) done = 1'b1;
            else if (word == "#") code = $fgets(line, fd);   // Comment line
            else if (word == "S") begin
                code = $fscanf(fd, "%d %d %d %h", port, dx, dy, payload);
                send_trans(port, dx, dy, payload);
            end else if (word == "M") begin
                code = $fscanf(fd, "%d %b", port, mask);
                set_mask(port, mask);
            end else if (word == "D") begin
                code = $fscanf(fd, "%d", port);
                drain(port);
            end else begin
                $display("Unknown record type in the data file");
                stop_on_failure();
            end
        end
        $fclose(fd);
        if (pending() != 0) begin
            $display("%0d expected transactions were never delivered", pending());
            stop_on_failure();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule : tb_router_tile

// File: flist.f
verilog/router_cfg_pkg.sv
verilog/router_pkg.sv
verilog/fifo.sv
verilog/rr_arbiter.sv
verilog/route_decoder.sv
verilog/fifo_arb.sv
verilog/router_tile.sv
dv/tb_router_tile.sv

// File: verilog/fifo.sv
// Synchronous FIFO
// Circular buffer with occupancy count, head word always driven on pop_data

module fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  logic [DATA_WIDTH-1:0] push_data,
    input  logic                  pop,
    output logic [DATA_WIDTH-1:0] pop_data,
    output logic                  full,
    output logic                  empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];  // Storage array
    logic [PTR_W-1:0]      wr_ptr;            // Next slot to write
    logic [PTR_W-1:0]      rd_ptr;            // Current head slot
    logic [CNT_W-1:0]      count;             // Entries held

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Idle or push with pop
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    assign pop_data = mem[rd_ptr];            // Head visible the cycle after push
    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);

    // Upstream must respect the ready level derived from full
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) full |-> !push);
    // Arbiter must only pick FIFOs holding data
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) empty |-> !pop);

endmodule : fifo

// File: verilog/fifo_arb.sv
// Output FIFO arbiter
// One FIFO per source, round-robin over heads whose next-tile arbiter is ready

module fifo_arb #(
    parameter int NUM_CLIENTS = router_cfg_pkg::NUM_CLIENTS
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    // ========================================================================
    // Client side, one slot per source port
    // ========================================================================
    input  logic [NUM_CLIENTS-1:0]                    push,
    input  router_pkg::t_tile_trans [NUM_CLIENTS-1:0] push_req,
    output logic [NUM_CLIENTS-1:0]                    client_ready,
    // ========================================================================
    // Toward the neighbor tile
    // ========================================================================
    output router_pkg::t_tile_trans                   winner_req,
    output logic                                      winner_req_valid,
    input  router_pkg::t_port_ready                   in_ready     // Neighbor arbiters
);

    import router_cfg_pkg::*;
    import router_pkg::*;

    t_tile_trans [NUM_CLIENTS-1:0] head;            // FIFO heads
    logic [NUM_CLIENTS-1:0]        full;
    logic [NUM_CLIENTS-1:0]        empty;
    logic [NUM_CLIENTS-1:0]        fifo_pop;
    logic [NUM_CLIENTS-1:0]        valid_candidate;
    logic [NUM_CLIENTS-1:0]        winner_dec_id;   // One-hot grant

    for (genvar i = 0; i < NUM_CLIENTS; i++) begin : gen_fifo
        fifo #(
            .DATA_WIDTH ($bits(t_tile_trans)),
            .FIFO_DEPTH (ARB_FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push[i]),
            .push_data (push_req[i]),
            .pop       (fifo_pop[i]),
            .pop_data  (head[i]),
            .full      (full[i]),
            .empty     (empty[i])
        );
    end

    assign client_ready = ~full;   // Back-pressure to senders

    // Candidate needs data and a ready target arbiter in the next tile
    always_comb begin
        valid_candidate = '0;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            for (int c = 0; c < NUM_PORTS; c++) begin
                if (!empty[i] && head[i].next_tile_fifo_arb_id == t_cardinal'(c) &&
                    in_ready[c])
                    valid_candidate[i] = 1'b1;
            end
        end
    end

    rr_arbiter #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) u_arb (
        .clk             (clk),
        .rst_n           (rst_n),
        .valid_candidate (valid_candidate),
        .winner_dec_id   (winner_dec_id)
    );

    assign fifo_pop         = winner_dec_id;    // Winner leaves in the grant cycle
    assign winner_req_valid = |winner_dec_id;

    // AND-OR mux of the granted head
    always_comb begin
        winner_req = '0;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            if (winner_dec_id[i])
                winner_req = winner_req | head[i];
        end
    end

    // A pop always takes a held head whose target was ready
    a_pop_valid_winner: assert property (@(posedge clk) disable iff (!rst_n)
        (|fifo_pop) |-> ((fifo_pop & empty) == '0) &&
                        in_ready[winner_req.next_tile_fifo_arb_id]);

endmodule : fifo_arb

// File: verilog/route_decoder.sv
// XY route decoder
// Picks this tile's output, stamps the next tile's arbiter and steers the push strobe

module route_decoder #(
    parameter int TILE_X = 0,
    parameter int TILE_Y = 0
) (
    input  logic                                 in_valid,
    input  router_pkg::t_tile_trans              in_req,
    output logic [router_cfg_pkg::NUM_PORTS-1:0] push_arb,
    output router_pkg::t_tile_trans              out_req
);

    import router_cfg_pkg::*;
    import router_pkg::*;

    localparam logic [MESH_X_W-1:0] MY_X = MESH_X_W'(TILE_X);
    localparam logic [MESH_Y_W-1:0] MY_Y = MESH_Y_W'(TILE_Y);

    t_cardinal           out_port;  // Output of this tile
    t_cardinal           stamp;     // Arbiter in the neighbor
    logic [MESH_X_W-1:0] nb_x;      // Neighbor coordinates
    logic [MESH_Y_W-1:0] nb_y;

    // X first, then Y, else deliver locally
    function automatic t_cardinal xy_route(input logic [MESH_X_W-1:0] cur_x,
                                           input logic [MESH_Y_W-1:0] cur_y,
                                           input t_coord              dest);
        t_cardinal dir;
        if (dest.x > cur_x)      dir = EAST;
        else if (dest.x < cur_x) dir = WEST;
        else if (dest.y > cur_y) dir = NORTH;
        else if (dest.y < cur_y) dir = SOUTH;
        else                     dir = LOCAL;
        return dir;
    endfunction

    always_comb begin
        out_port = xy_route(MY_X, MY_Y, in_req.dest);
        nb_x     = MY_X;
        nb_y     = MY_Y;
        case (out_port)
            EAST:    nb_x = MY_X + 1'b1;
            WEST:    nb_x = MY_X - 1'b1;
            NORTH:   nb_y = MY_Y + 1'b1;
            SOUTH:   nb_y = MY_Y - 1'b1;
            default: ;                        // Local, no hop
        endcase
        // Same decision as the neighbor will make
        stamp = (out_port == LOCAL) ? LOCAL : xy_route(nb_x, nb_y, in_req.dest);

        out_req                       = in_req;
        out_req.next_tile_fifo_arb_id = stamp;
        push_arb                      = '0;
        push_arb[out_port]            = in_valid;  // Strobe to chosen arbiter only
    end

endmodule : route_decoder

// File: verilog/router_cfg_pkg.sv
// Router configuration package
// Mesh coordinate widths and buffer sizing shared by every tile block

package router_cfg_pkg;

    // ========================================================================
    // Mesh geometry
    // ========================================================================
    localparam int MESH_X_W       = 2;  // 4 columns
    localparam int MESH_Y_W       = 2;  // 4 rows

    // ========================================================================
    // Tile ports and buffering
    // ========================================================================
    localparam int NUM_PORTS      = 5;  // N, E, S, W, local
    localparam int NUM_CLIENTS    = 4;  // Sources per output, no U-turn
    localparam int ARB_FIFO_DEPTH = 4;  // Entries per client FIFO
    localparam int PAYLOAD_W      = 16; // Data carried per transaction

endpackage : router_cfg_pkg

// File: verilog/router_pkg.sv
// Router types package
// Transaction format, port naming and ready vectors passed between tiles

package router_pkg;

    // Port and arbiter naming, also the stamp for the next tile
    typedef enum logic [2:0] {
        NORTH = 3'd0,   // y + 1
        EAST  = 3'd1,   // x + 1
        SOUTH = 3'd2,   // y - 1
        WEST  = 3'd3,   // x - 1
        LOCAL = 3'd4    // Core attached to this tile
    } t_cardinal;

    // Tile position in the mesh
    typedef struct packed {
        logic [router_cfg_pkg::MESH_X_W-1:0] x;
        logic [router_cfg_pkg::MESH_Y_W-1:0] y;
    } t_coord;

    // ========================================================================
    // Transaction moving through the mesh, 27 bits
    // ========================================================================
    typedef struct packed {
        t_coord                               src;                   // Origin tile
        t_coord                               dest;                  // Final tile
        t_cardinal                            next_tile_fifo_arb_id; // Arbiter to use next hop
        logic [router_cfg_pkg::PAYLOAD_W-1:0] payload;
    } t_tile_trans;

    // One ready level per arbiter of a tile, indexed by t_cardinal
    typedef logic [router_cfg_pkg::NUM_PORTS-1:0] t_port_ready;

endpackage : router_pkg

// File: verilog/router_tile.sv
// Mesh router tile
// Five XY route decoders feeding five output FIFO arbiters through the crossbar

module router_tile #(
    parameter int TILE_X = 0,
    parameter int TILE_Y = 0
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    // From neighbors
    input  logic [router_cfg_pkg::NUM_PORTS-1:0]                   in_valid,
    input  router_pkg::t_tile_trans [router_cfg_pkg::NUM_PORTS-1:0] in_req,
    output router_pkg::t_port_ready [router_cfg_pkg::NUM_PORTS-1:0] out_ready,
    // To neighbors
    output router_pkg::t_tile_trans [router_cfg_pkg::NUM_PORTS-1:0] winner_req,
    output logic [router_cfg_pkg::NUM_PORTS-1:0]                   winner_req_valid,
    input  router_pkg::t_port_ready [router_cfg_pkg::NUM_PORTS-1:0] in_ready
);

    import router_cfg_pkg::*;
    import router_pkg::*;

    logic [NUM_PORTS-1:0][NUM_PORTS-1:0]       dec_push;   // [source][arbiter]
    t_tile_trans [NUM_PORTS-1:0]               dec_req;    // Stamped transactions
    logic [NUM_PORTS-1:0][NUM_CLIENTS-1:0]     arb_push;   // [arbiter][slot]
    t_tile_trans [NUM_PORTS-1:0][NUM_CLIENTS-1:0] arb_req;
    logic [NUM_PORTS-1:0][NUM_CLIENTS-1:0]     arb_ready;

    // ========================================================================
    // Crossbar, slot s of arbiter d serves the s-th port other than d
    // ========================================================================
    always_comb begin
        int src;
        out_ready = '1;                           // U-turn bits are never targeted
        for (int d = 0; d < NUM_PORTS; d++) begin
            for (int s = 0; s < NUM_CLIENTS; s++) begin
                src               = (s < d) ? s : s + 1;
                arb_push[d][s]    = dec_push[src][d];
                arb_req[d][s]     = dec_req[src];
                out_ready[src][d] = arb_ready[d][s];
            end
        end
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
        route_decoder #(
            .TILE_X (TILE_X),
            .TILE_Y (TILE_Y)
        ) u_dec (
            .in_valid (in_valid[p]),
            .in_req   (in_req[p]),
            .push_arb (dec_push[p]),
            .out_req  (dec_req[p])
        );

        fifo_arb #(
            .NUM_CLIENTS (NUM_CLIENTS)
        ) u_fifo_arb (
            .clk              (clk),
            .rst_n            (rst_n),
            .push             (arb_push[p]),
            .push_req         (arb_req[p]),
            .client_ready     (arb_ready[p]),
            .winner_req       (winner_req[p]),
            .winner_req_valid (winner_req_valid[p]),
            .in_ready         (in_ready[p])
        );

        // XY traffic never heads back out the port it came in on
        a_no_uturn: assert property (@(posedge clk) disable iff (!rst_n) !dec_push[p][p]);
    end

endmodule : router_tile

// File: verilog/rr_arbiter.sv
// Round-robin arbiter
// One-hot grant from the first candidate at or after a rotating pointer

module rr_arbiter #(
    parameter int NUM_CLIENTS = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [NUM_CLIENTS-1:0] valid_candidate,
    output logic [NUM_CLIENTS-1:0] winner_dec_id
);

    localparam int PTR_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

    logic [PTR_W-1:0] prio_ptr;   // Highest priority client this cycle
    logic [PTR_W-1:0] win_idx;    // Encoded winner
    logic             grant_any;

    // Scan clients starting at the pointer, wrapping around
    always_comb begin
        int idx;
        winner_dec_id = '0;
        win_idx       = '0;
        grant_any     = 1'b0;
        for (int off = 0; off < NUM_CLIENTS; off++) begin
            idx = int'(prio_ptr) + off;
            if (idx >= NUM_CLIENTS)
                idx = idx - NUM_CLIENTS;
            if (!grant_any && valid_candidate[idx]) begin
                grant_any = 1'b1;
                win_idx   = PTR_W'(idx);
            end
        end
        if (grant_any)
            winner_dec_id[win_idx] = 1'b1;
    end

    // Pointer moves just past the winner, holds when nothing granted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            prio_ptr <= '0;
        else if (grant_any)
            prio_ptr <= (win_idx == PTR_W'(NUM_CLIENTS - 1)) ? '0 : win_idx + 1'b1;
    end

    a_grant_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(winner_dec_id) && ((winner_dec_id & ~valid_candidate) == '0));

endmodule : rr_arbiter
